// File: Bender.yml
package:
  name: rv_icache

sources:
  - design/icache_pkg.sv
  - design/icache_tag_store.sv
  - design/icache_line_store.sv
  - design/fetch_align.sv
  - design/icache_ctrl.sv
  - design/rv_icache.sv
  - target: simulation
    files:
      - sim/tb_rv_icache.sv

// File: design/fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
  input  icache_pkg::fetch_addr_t       req_addr_i,
  input  icache_pkg::line_t             line_i,
  input  logic                          uncached_sel_i,
  input  logic [icache_pkg::ADDR_W-1:0] uncached_word_i,
  input  logic                          rsp_pulse_i,
  output logic [icache_pkg::ADDR_W-1:0] insn_o,
  output logic                          insn_valid_o
);

  localparam int HALVES = icache_pkg::LINE_BEATS * 2;
  localparam int HW_W   = icache_pkg::OFFSET_W - 1;

  logic [HW_W-1:0]               hw_idx;
  logic [HW_W-1:0]               next_idx;
  logic                          at_line_end;
  logic [15:0]                   lo_half;
  logic [15:0]                   hi_half;
  logic                          is_32bit;
  logic [icache_pkg::ADDR_W-1:0] cache_insn;
  logic [icache_pkg::ADDR_W-1:0] raw_insn;

  // halfword slot within the line ignoring byte bit 0
  assign hw_idx      = req_addr_i.offset[icache_pkg::OFFSET_W-1:1];
  assign at_line_end = hw_idx == HW_W'(HALVES - 1);
  assign next_idx    = hw_idx + 1'b1;

  assign lo_half = line_i[hw_idx*16 +: 16];
  // upper half is zero at the line end since fetch never crosses lines
  assign hi_half = at_line_end ? 16'h0000 : line_i[next_idx*16 +: 16];

  // low bits 11 mark a full-width instruction
  assign is_32bit   = lo_half[1:0] == 2'b11;
  assign cache_insn = is_32bit ? {hi_half, lo_half} : {16'h0000, lo_half};

  assign raw_insn = uncached_sel_i ? uncached_word_i : cache_insn;
  // an all-zero word becomes a nop
  assign insn_o = (raw_insn == '0) ? icache_pkg::NOP_INSN : raw_insn;

  assign insn_valid_o = rsp_pulse_i;

endmodule

// File: design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
  parameter logic [icache_pkg::ADDR_W-1:0] UNCACHED_BASE = 32'h1000_0000,
  parameter logic [icache_pkg::ADDR_W-1:0] UNCACHED_MASK = 32'hF000_0000
) (
  input  logic                          clk,
  input  logic                          rst,
  input  icache_pkg::fetch_addr_t       fetch_addr_i,
  input  logic                          fetch_valid_i,
  input  logic                          hit_i,
  input  icache_pkg::mem_rsp_t          mem_rsp_i,
  output icache_pkg::fetch_addr_t       req_addr_o,
  output icache_pkg::mem_req_t          mem_req_o,
  output logic [icache_pkg::BEAT_W-1:0] beat_idx_o,
  output logic                          beat_we_o,
  output logic                          tag_we_o,
  output logic                          uncached_sel_o,
  output logic [icache_pkg::ADDR_W-1:0] uncached_word_o,
  output logic                          rsp_pulse_o
);

  icache_pkg::ctrl_state_e       state_q;
  icache_pkg::fetch_addr_t       req_addr_q;
  icache_pkg::mem_req_t          mem_req_q;
  logic [icache_pkg::BEAT_W-1:0] beat_cnt_q;
  logic [icache_pkg::ADDR_W-1:0] uncached_word_q;
  logic                          rsp_pulse_q;
  logic [icache_pkg::ADDR_W-1:0] req_addr_flat;
  logic                          is_uncached;
  logic                          handshake;
  logic                          last_beat;
  logic                          accept;

  assign req_addr_flat = req_addr_q;
  // uncached region decode on the held address
  assign is_uncached = (req_addr_flat & UNCACHED_MASK) == UNCACHED_BASE;
  // one beat moves per cycle with valid and ready
  assign handshake = mem_req_q.valid && mem_rsp_i.ready;
  assign last_beat = beat_cnt_q == mem_req_q.len[icache_pkg::BEAT_W-1:0];
  // no new accept in the pulse cycle while the requester still holds valid
  assign accept = (state_q == icache_pkg::ST_IDLE) && fetch_valid_i && !rsp_pulse_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= icache_pkg::ST_RESET;
      mem_req_q   <= '0;
      beat_cnt_q  <= '0;
      rsp_pulse_q <= 1'b0;
    end else begin
      rsp_pulse_q <= 1'b0;
      case (state_q)
        icache_pkg::ST_RESET: begin
          state_q <= icache_pkg::ST_IDLE;
        end
        icache_pkg::ST_IDLE: begin
          if (accept) begin
            state_q <= icache_pkg::ST_LOOKUP;
          end
        end
        icache_pkg::ST_LOOKUP: begin
          if (is_uncached) begin
            // single beat at the exact fetch address
            state_q         <= icache_pkg::ST_UNCACHED;
            mem_req_q.addr  <= req_addr_flat;
            mem_req_q.valid <= 1'b1;
            mem_req_q.len   <= 8'd0;
            beat_cnt_q      <= '0;
          end else if (hit_i) begin
            state_q     <= icache_pkg::ST_IDLE;
            rsp_pulse_q <= 1'b1;
          end else begin
            // burst from the line base
            state_q         <= icache_pkg::ST_REFILL;
            mem_req_q.addr  <= {req_addr_q.tag, req_addr_q.index,
                                {icache_pkg::OFFSET_W{1'b0}}};
            mem_req_q.valid <= 1'b1;
            mem_req_q.len   <= 8'(icache_pkg::LINE_BEATS - 1);
            beat_cnt_q      <= '0;
          end
        end
        icache_pkg::ST_REFILL: begin
          if (handshake) begin
            if (last_beat) begin
              // tag written on this edge so the next lookup hits
              mem_req_q.valid <= 1'b0;
              state_q         <= icache_pkg::ST_LOOKUP;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        icache_pkg::ST_UNCACHED: begin
          if (handshake) begin
            mem_req_q.valid <= 1'b0;
            rsp_pulse_q     <= 1'b1;
            state_q         <= icache_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // held fetch address and uncached data word
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q <= fetch_addr_i;
    end
    if (state_q == icache_pkg::ST_UNCACHED && handshake) begin
      uncached_word_q <= mem_rsp_i.data;
    end
  end

  assign req_addr_o      = req_addr_q;
  assign mem_req_o       = mem_req_q;
  assign beat_idx_o      = beat_cnt_q;
  assign beat_we_o       = (state_q == icache_pkg::ST_REFILL) && handshake;
  assign tag_we_o        = (state_q == icache_pkg::ST_REFILL) && handshake && last_beat;
  assign uncached_sel_o  = is_uncached;
  assign uncached_word_o = uncached_word_q;
  assign rsp_pulse_o     = rsp_pulse_q;

  // request stays up until a beat completes it
  assert property (@(posedge clk) disable iff (rst)
    mem_req_q.valid && !handshake |=> mem_req_q.valid);

  // burst counter bounded by the requested length
  assert property (@(posedge clk) disable iff (rst)
    mem_req_q.valid |-> beat_cnt_q <= mem_req_q.len);

endmodule

// File: design/icache_line_store.sv
`timescale 1ns/1ps

module icache_line_store (
  input  logic                          clk,
  input  icache_pkg::fetch_addr_t       req_addr_i,
  input  logic [icache_pkg::BEAT_W-1:0] beat_idx_i,
  input  logic                          beat_we_i,
  input  icache_pkg::mem_rsp_t          mem_rsp_i,
  output icache_pkg::line_t             line_o
);

  localparam int LINES = 2 ** icache_pkg::INDEX_W;

  // whole-line array with word k at bits k*32 upward
  icache_pkg::line_t line_q [LINES];

  // one refill word per beat into its slot
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      line_q[req_addr_i.index][beat_idx_i*icache_pkg::ADDR_W +: icache_pkg::ADDR_W]
        <= mem_rsp_i.data;
    end
  end

  // asynchronous read of the addressed line
  assign line_o = line_q[req_addr_i.index];

  // write slot must be a known word of the line
  assert property (@(posedge clk)
    beat_we_i |-> !$isunknown(beat_idx_i));

endmodule

// File: design/icache_pkg.sv
package icache_pkg;

  // address geometry of the 8 KB direct-mapped cache
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 7;
  localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;

  // refill burst shape, one 32-bit word per beat
  localparam int LINE_BEATS = 16;
  localparam int BEAT_W     = 4;

  // canonical nop, addi x0, x0, 0
  localparam logic [ADDR_W-1:0] NOP_INSN = 32'h0000_0013;

  // fetch address split into its cache fields
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } fetch_addr_t;

  // one full cache line, word 0 in the low bits
  typedef logic [LINE_BEATS*ADDR_W-1:0] line_t;

  // memory read request, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              valid;
    logic [7:0]        len;
  } mem_req_t;

  // memory read response, data qualified by ready
  typedef struct packed {
    logic              ready;
    logic [ADDR_W-1:0] data;
  } mem_rsp_t;

  // controller states
  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } ctrl_state_e;

endpackage

// File: design/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::fetch_addr_t req_addr_i,
  input  logic                    tag_we_i,
  output logic                    hit_o
);

  localparam int LINES = 2 ** icache_pkg::INDEX_W;

  // one valid bit per line, cleared on reset
  logic [LINES-1:0]             valid_q;
  // tags, only meaningful where valid is set
  logic [icache_pkg::TAG_W-1:0] tag_q [LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[req_addr_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[req_addr_i.index] <= req_addr_i.tag;
    end
  end

  // combinational compare against the registered address
  assign hit_o = valid_q[req_addr_i.index] &&
                 (tag_q[req_addr_i.index] == req_addr_i.tag);

endmodule

// File: design/rv_icache.sv
`timescale 1ns/1ps

module rv_icache #(
  parameter logic [icache_pkg::ADDR_W-1:0] UNCACHED_BASE = 32'h1000_0000,
  parameter logic [icache_pkg::ADDR_W-1:0] UNCACHED_MASK = 32'hF000_0000
) (
  input  logic                          clk,
  input  logic                          rst,
  input  icache_pkg::fetch_addr_t       fetch_addr_i,
  input  logic                          fetch_valid_i,
  output logic [icache_pkg::ADDR_W-1:0] insn_o,
  output logic                          insn_valid_o,
  output icache_pkg::mem_req_t          mem_req_o,
  input  icache_pkg::mem_rsp_t          mem_rsp_i
);

  icache_pkg::fetch_addr_t         req_addr;
  logic [icache_pkg::BEAT_W-1:0]   beat_idx;
  logic                            beat_we;
  logic                            tag_we;
  logic                            hit;
  icache_pkg::line_t               line;
  logic                            uncached_sel;
  logic [icache_pkg::ADDR_W-1:0]   uncached_word;
  logic                            rsp_pulse;

  // sequencing and memory request
  icache_ctrl #(
    .UNCACHED_BASE (UNCACHED_BASE),
    .UNCACHED_MASK (UNCACHED_MASK)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_valid_i   (fetch_valid_i),
    .hit_i           (hit),
    .mem_rsp_i       (mem_rsp_i),
    .req_addr_o      (req_addr),
    .mem_req_o       (mem_req_o),
    .beat_idx_o      (beat_idx),
    .beat_we_o       (beat_we),
    .tag_we_o        (tag_we),
    .uncached_sel_o  (uncached_sel),
    .uncached_word_o (uncached_word),
    .rsp_pulse_o     (rsp_pulse)
  );

  icache_tag_store u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .req_addr_i (req_addr),
    .tag_we_i   (tag_we),
    .hit_o      (hit)
  );

  icache_line_store u_line_store (
    .clk        (clk),
    .req_addr_i (req_addr),
    .beat_idx_i (beat_idx),
    .beat_we_i  (beat_we),
    .mem_rsp_i  (mem_rsp_i),
    .line_o     (line)
  );

  // output side, halfword pick and rvc decode
  fetch_align u_fetch_align (
    .req_addr_i      (req_addr),
    .line_i          (line),
    .uncached_sel_i  (uncached_sel),
    .uncached_word_i (uncached_word),
    .rsp_pulse_i     (rsp_pulse),
    .insn_o          (insn_o),
    .insn_valid_o    (insn_valid_o)
  );

endmodule

// File: rv_icache.f
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_line_store.sv
design/fetch_align.sv
design/icache_ctrl.sv
design/rv_icache.sv
sim/tb_rv_icache.sv

// File: sim/tb_rv_icache.sv
`timescale 1ns/1ps

module tb_rv_icache;

  localparam int          CLK_HALF       = 10;
  localparam int          RST_CYCLES     = 8;
  localparam int          TIMEOUT        = 500;
  localparam int          N_ENTRIES      = 21;
  localparam logic [31:0] UNC_BASE       = 32'h1000_0000;
  localparam logic [31:0] UNC_MASK       = 32'hF000_0000;
  // one word of memory reads back as zero
  localparam logic [31:0] ZERO_WORD_ADDR = 32'h0000_0a88;

  logic                    clk = 1'b0;
  logic                    rst;
  icache_pkg::fetch_addr_t fetch_addr;
  logic                    fetch_valid;
  logic [31:0]             insn;
  logic                    insn_valid;
  icache_pkg::mem_req_t    mem_req;
  icache_pkg::mem_rsp_t    mem_rsp;

  // stimulus table with expected insn filled from the memory content
  logic [31:0] tbl_addr [N_ENTRIES];
  int          tbl_reqs [N_ENTRIES];
  logic        tbl_bp   [N_ENTRIES];
  logic [31:0] tbl_insn [N_ENTRIES];
  int          n_filled;

  // memory model bookkeeping
  integer      seed;
  int          req_count;
  int          beat_cnt;
  logic        req_active;
  logic        hs_pending;
  logic [31:0] burst_base;
  logic [7:0]  burst_len;
  logic        bp_mode;
  logic [31:0] cur_addr;

  rv_icache #(
    .UNCACHED_BASE (UNC_BASE),
    .UNCACHED_MASK (UNC_MASK)
  ) u_rv_icache (
    .clk           (clk),
    .rst           (rst),
    .fetch_addr_i  (fetch_addr),
    .fetch_valid_i (fetch_valid),
    .insn_o        (insn),
    .insn_valid_o  (insn_valid),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic in_uncached_region(input logic [31:0] a);
    return (a & UNC_MASK) == UNC_BASE;
  endfunction

  // halfword content derived from the byte address
  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [15:0] h;
    h[15:2] = a[15:2] ^ a[29:16] ^ 14'h2b5d;
    h[1:0]  = a[2:1] ^ a[4:3];
    // line start always compressed
    if (a[5:1] == 5'd0) begin
      h[1:0] = 2'b01;
    end
    // line end always full width
    if (a[5:1] == 5'd31) begin
      h[1:0] = 2'b11;
    end
    if (a[31:2] == ZERO_WORD_ADDR[31:2]) begin
      h = 16'h0000;
    end
    return h;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    return {mem_half(wa + 32'd2), mem_half(wa)};
  endfunction

  // expected fetch result from the alignment rules
  function automatic logic [31:0] expect_insn(input logic [31:0] a);
    logic [31:0] ha;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] w;
    ha = {a[31:1], 1'b0};
    if (in_uncached_region(a)) begin
      w = mem_word(a);
    end else begin
      lo = mem_half(ha);
      // no crossing into the next line
      hi = (ha[5:1] == 5'd31) ? 16'h0000 : mem_half(ha + 32'd2);
      w  = (lo[1:0] == 2'b11) ? {hi, lo} : {16'h0000, lo};
    end
    if (w == 32'h0) begin
      w = 32'h0000_0013;
    end
    return w;
  endfunction

  task automatic stop_on_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic add_entry(input logic [31:0] a, input int reqs, input logic bp);
    tbl_addr[n_filled] = a;
    tbl_reqs[n_filled] = reqs;
    tbl_bp[n_filled]   = bp;
    tbl_insn[n_filled] = expect_insn(a);
    n_filled++;
  endtask

  task automatic fill_table();
    n_filled = 0;
    // cold miss then hits across the line
    add_entry(32'h0000_0400, 1, 1'b0);
    add_entry(32'h0000_0402, 0, 1'b0);
    add_entry(32'h0000_0404, 0, 1'b0);
    add_entry(32'h0000_0406, 0, 1'b0);
    add_entry(32'h0000_0412, 0, 1'b0);
    add_entry(32'h0000_041a, 0, 1'b0);
    add_entry(32'h0000_043e, 0, 1'b0);
    // uncached region where every fetch goes out
    add_entry(32'h1000_0100, 1, 1'b0);
    add_entry(32'h1000_0100, 1, 1'b0);
    add_entry(32'h1000_0206, 1, 1'b0);
    // zero word gives nop
    add_entry(32'h0000_0a88, 1, 1'b0);
    add_entry(32'h0000_0a8a, 0, 1'b0);
    // same index with another tag evicts line 16
    add_entry(32'h0000_2400, 1, 1'b0);
    add_entry(32'h0000_0406, 1, 1'b0);
    add_entry(32'h0000_0406, 0, 1'b0);
    // random gaps in ready
    add_entry(32'h0000_0810, 1, 1'b1);
    add_entry(32'h0000_0822, 0, 1'b1);
    add_entry(32'h1000_0300, 1, 1'b1);
    add_entry(32'h0000_2426, 1, 1'b1);
    add_entry(32'h0000_0c3e, 1, 1'b1);
    add_entry(32'h0000_0c3c, 0, 1'b1);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    for (int n = 0; n < RST_CYCLES; n++) begin
      @(negedge clk);
    end
    check_equal("mem_req_o.valid", mem_req.valid, 1'b0);
    check_equal("insn_valid_o", insn_valid, 1'b0);
    rst = 1'b0;
    // one cycle in the reset state before idle
    @(negedge clk);
  endtask

  // cycles counted from the negedge that raised fetch valid
  task automatic wait_insn_valid(output int cycles);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("timeout: no instruction came back within %0d cycles", TIMEOUT);
        stop_on_failure();
      end
    end while (insn_valid !== 1'b1);
    cycles = n;
  endtask

  task automatic run_entry(input int i);
    int start_reqs;
    int cycles;
    cur_addr    = tbl_addr[i];
    bp_mode     = tbl_bp[i];
    start_reqs  = req_count;
    fetch_addr  = tbl_addr[i];
    fetch_valid = 1'b1;
    wait_insn_valid(cycles);
    check_equal("insn_o", insn, tbl_insn[i]);
    check_equal("request count", req_count - start_reqs, tbl_reqs[i]);
    if (tbl_reqs[i] == 0) begin
      check_equal("hit latency", cycles, 2);
    end
    // pulse must be gone once valid drops
    fetch_valid = 1'b0;
    @(negedge clk);
    check_equal("insn_valid_o", insn_valid, 1'b0);
  endtask

  // memory model responding on the falling edge
  always @(negedge clk) begin
    logic [31:0] rnd;
    if (hs_pending) begin
      beat_cnt++;
    end
    if (mem_req.valid && !req_active) begin
      req_active = 1'b1;
      req_count++;
      beat_cnt   = 0;
      burst_base = mem_req.addr;
      burst_len  = mem_req.len;
      if (in_uncached_region(cur_addr)) begin
        check_equal("mem_req_o.addr", mem_req.addr, cur_addr);
        check_equal("mem_req_o.len", mem_req.len, 8'd0);
      end else begin
        check_equal("mem_req_o.addr", mem_req.addr, {cur_addr[31:6], 6'b0});
        check_equal("mem_req_o.len", mem_req.len, 8'd15);
      end
    end else if (!mem_req.valid && req_active) begin
      // all beats must be done once the request drops
      req_active = 1'b0;
      check_equal("burst beats", beat_cnt, burst_len + 1);
    end
    rnd = $random(seed);
    if (mem_req.valid) begin
      if (beat_cnt > burst_len) begin
        $display("memory saw more beats than the request length allows");
        stop_on_failure();
      end
      mem_rsp.ready = bp_mode ? rnd[0] : 1'b1;
      mem_rsp.data  = mem_word({burst_base[31:2], 2'b00} + 32'(4 * beat_cnt));
    end else begin
      mem_rsp.ready = 1'b0;
      mem_rsp.data  = '0;
    end
    // beat moves on the coming rising edge
    hs_pending = mem_req.valid && mem_rsp.ready;
  end

  initial begin
    seed        = 32'h5671ab58;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    mem_rsp     = '0;
    req_count   = 0;
    beat_cnt    = 0;
    req_active  = 1'b0;
    hs_pending  = 1'b0;
    burst_base  = '0;
    burst_len   = '0;
    bp_mode     = 1'b0;
    cur_addr    = '0;
    fill_table();
    apply_reset();
    for (int i = 0; i < N_ENTRIES; i++) begin
      run_entry(i);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule
